// ==== src/rv32i_macros.svh ====
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// data and address width
`define XLEN 32

// register index width and count
`define REG_ADDR_W 5
`define NUM_REGS 32

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

// ==== src/rv32i_pkg.sv ====
`default_nettype none

`include "rv32i_macros.svh"

package rv32i_pkg;

    // major opcodes handled by the core, anything else is a no-op
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // operand source in execute
    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

    // all-zero word is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    use_lui;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t              ctrl;
        logic [`XLEN-1:0]        rs1_data;
        logic [`XLEN-1:0]        rs2_data;
        logic [`XLEN-1:0]        imm;
        logic [`REG_ADDR_W-1:0]  rs1;
        logic [`REG_ADDR_W-1:0]  rs2;
        logic [`REG_ADDR_W-1:0]  rd;
    } id_ex_t;

    typedef struct packed {
        logic                   reg_write;
        logic                   mem_read;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       alu_out;
        logic [`XLEN-1:0]       load_data;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== src/ex_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

// EX/MEM pipeline register contents
interface ex_mem_if
    import rv32i_pkg::*;
();
    ctrl_word_t             ctrl;
    logic [`XLEN-1:0]       alu_out;
    // store data, already forwarded in execute
    logic [`XLEN-1:0]       rs2_data;
    logic [`REG_ADDR_W-1:0] rd;

    // execute owns the register
    modport ex (output ctrl, output alu_out, output rs2_data, output rd);
    modport mem (input ctrl, input alu_out, input rs2_data, input rd);
    // hazard compare only needs the destination
    modport fwd (input ctrl, input rd);
endinterface

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module fetch_unit (
    input  wire logic             clk,
    input  wire logic             rst_n_i,
    input  wire logic [`XLEN-1:0] instr_rdata_i,
    output logic      [`XLEN-1:0] pc_o,
    output logic      [`XLEN-1:0] instr_o
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] instr_q;

    // no branches, so sequential fetch only
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_q + `XLEN'd4;
        end
    end

    // IF/ID register
    // zero word has opcode 0 and decodes as a bubble
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instr_q <= '0;
        end else begin
            instr_q <= instr_rdata_i;
        end
    end

    assign pc_o    = pc_q;
    assign instr_o = instr_q;

endmodule

`default_nettype wire

// ==== src/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module regfile (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire logic [`REG_ADDR_W-1:0] rs1_i,
    input  wire logic [`REG_ADDR_W-1:0] rs2_i,
    input  wire logic                   we_i,
    input  wire logic [`REG_ADDR_W-1:0] rd_i,
    input  wire logic [`XLEN-1:0]       wd_i,
    output logic      [`XLEN-1:0]       rs1_data_o,
    output logic      [`XLEN-1:0]       rs2_data_o
);

    logic [`XLEN-1:0] regs_q [`NUM_REGS];

    // write-through, a same-cycle write is seen by decode
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (we_i && (rd_i != '0) && (rd_i == addr)) begin
            return wd_i;
        end
        return regs_q[addr];
    endfunction

    // x0 is never written so it stays at its reset zero
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs_q[rd_i] <= wd_i;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

`default_nettype wire

// ==== src/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module decode_unit
    import rv32i_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire logic [`XLEN-1:0]       instr_i,
    // writeback bus from the MEM/WB register
    input  wire logic                   wb_we_i,
    input  wire logic [`REG_ADDR_W-1:0] wb_rd_i,
    input  wire logic [`XLEN-1:0]       wb_data_i,
    output id_ex_t                      id_ex_o
);

    opcode_e                opcode;
    logic [2:0]             funct3;
    logic                   funct7_alt;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       imm;
    ctrl_word_t             ctrl;
    id_ex_t                 id_ex_d;
    id_ex_t                 id_ex_q;

    // funct3 to ALU op, shared by OP and OP-IMM
    // bit 30 picks SUB only for register form, SRA for both
    function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic alt,
                                             input logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && alt) ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    // instruction fields
    assign opcode     = opcode_e'(instr_i[6:0]);
    assign rd         = instr_i[11:7];
    assign funct3     = instr_i[14:12];
    assign rs1        = instr_i[19:15];
    assign rs2        = instr_i[24:20];
    assign funct7_alt = instr_i[30];

    regfile u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .we_i       (wb_we_i),
        .rd_i       (wb_rd_i),
        .wd_i       (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // control word and immediate per opcode
    // unknown opcodes leave a zero word
    always_comb begin
        ctrl = '0;
        imm  = {{20{instr_i[31]}}, instr_i[31:20]};
        case (opcode)
            op_lui: begin
                imm            = {instr_i[31:12], 12'b0};
                ctrl.use_imm   = 1'b1;
                ctrl.use_lui   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_imm: begin
                ctrl.alu_op    = funct_to_alu(funct3, funct7_alt, 1'b0);
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_reg: begin
                ctrl.alu_op    = funct_to_alu(funct3, funct7_alt, 1'b1);
                ctrl.reg_write = 1'b1;
            end
            op_load: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            op_store: begin
                // S-type splits the offset around rd
                imm            = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    always_comb begin
        id_ex_d.ctrl     = ctrl;
        id_ex_d.rs1_data = rs1_data;
        id_ex_d.rs2_data = rs2_data;
        id_ex_d.imm      = imm;
        id_ex_d.rs1      = rs1;
        id_ex_d.rs2      = rs2;
        id_ex_d.rd       = rd;
    end

    // ID/EX register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// ==== src/forwarder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module forwarder
    import rv32i_pkg::*;
(
    input  wire logic [`REG_ADDR_W-1:0] id_ex_rs1_i,
    input  wire logic [`REG_ADDR_W-1:0] id_ex_rs2_i,
    ex_mem_if.fwd                       mem_bus,
    input  wire logic                   wb_we_i,
    input  wire logic [`REG_ADDR_W-1:0] wb_rd_i,
    output fwd_sel_e                    fwd_a_o,
    output fwd_sel_e                    fwd_b_o
);

    // newest producer wins, x0 never forwards
    function automatic fwd_sel_e pick(input logic [`REG_ADDR_W-1:0] src);
        if (mem_bus.ctrl.reg_write && (mem_bus.rd != '0) && (mem_bus.rd == src)) begin
            return fwd_mem;
        end
        if (wb_we_i && (wb_rd_i != '0) && (wb_rd_i == src)) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    always_comb begin
        fwd_a_o = pick(id_ex_rs1_i);
        fwd_b_o = pick(id_ex_rs2_i);
    end

endmodule

`default_nettype wire

// ==== src/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module execute_unit
    import rv32i_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst_n_i,
    input  wire id_ex_t           id_ex_i,
    input  wire fwd_sel_e         fwd_a_i,
    input  wire fwd_sel_e         fwd_b_i,
    // value being written back this cycle
    input  wire logic [`XLEN-1:0] wb_data_i,
    ex_mem_if.ex                  mem_bus
);

    logic [`XLEN-1:0] rs1_fwd;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] opnd_a;
    logic [`XLEN-1:0] opnd_b;
    logic [`XLEN-1:0] alu_res;

    function automatic logic [`XLEN-1:0] alu(input alu_op_e op, input logic [`XLEN-1:0] a,
                                             input logic [`XLEN-1:0] b);
        logic [4:0] shamt;
        shamt = b[4:0];
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << shamt;
            alu_slt:  return {31'b0, $signed(a) < $signed(b)};
            alu_sltu: return {31'b0, a < b};
            alu_xor:  return a ^ b;
            alu_srl:  return a >> shamt;
            alu_sra:  return $signed(a) >>> shamt;
            alu_or:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    // forwarding muxes, EX/MEM result comes back off the bus
    function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                 input logic [`XLEN-1:0] reg_val);
        case (sel)
            fwd_mem: return mem_bus.alu_out;
            fwd_wb:  return wb_data_i;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        rs1_fwd = fwd_mux(fwd_a_i, id_ex_i.rs1_data);
        rs2_fwd = fwd_mux(fwd_b_i, id_ex_i.rs2_data);
        // LUI is 0 + U immediate
        opnd_a  = id_ex_i.ctrl.use_lui ? '0 : rs1_fwd;
        opnd_b  = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_fwd;
        alu_res = alu(id_ex_i.ctrl.alu_op, opnd_a, opnd_b);
    end

    // EX/MEM control
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_bus.ctrl <= '0;
        end else begin
            mem_bus.ctrl <= id_ex_i.ctrl;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        mem_bus.alu_out  <= alu_res;
        mem_bus.rs2_data <= rs2_fwd;
        mem_bus.rd       <= id_ex_i.rd;
    end

endmodule

`default_nettype wire

// ==== src/mem_wb_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module mem_wb_unit
    import rv32i_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    ex_mem_if.mem                       mem_bus,
    input  wire logic [`XLEN-1:0]       data_rdata_i,
    output logic      [`XLEN-1:0]       data_address_o,
    output logic      [`XLEN-1:0]       data_wdata_o,
    output logic                        data_read_o,
    output logic                        data_write_o,
    output logic                        wb_we_o,
    output logic      [`REG_ADDR_W-1:0] wb_rd_o,
    output logic      [`XLEN-1:0]       wb_data_o
);

    mem_wb_t mem_wb_q;

    // memory answers in the same cycle, strobes last one cycle
    assign data_address_o = mem_bus.alu_out;
    assign data_wdata_o   = mem_bus.rs2_data;
    assign data_read_o    = mem_bus.ctrl.mem_read;
    assign data_write_o   = mem_bus.ctrl.mem_write;

    // MEM/WB register, load data captured at end of memory cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q.reg_write <= mem_bus.ctrl.reg_write;
            mem_wb_q.mem_read  <= mem_bus.ctrl.mem_read;
            mem_wb_q.rd        <= mem_bus.rd;
            mem_wb_q.alu_out   <= mem_bus.alu_out;
            mem_wb_q.load_data <= data_rdata_i;
        end
    end

    // writeback select
    assign wb_we_o   = mem_wb_q.reg_write;
    assign wb_rd_o   = mem_wb_q.rd;
    assign wb_data_o = mem_wb_q.mem_read ? mem_wb_q.load_data : mem_wb_q.alu_out;

endmodule

`default_nettype wire

// ==== src/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32i_macros.svh"

module datapath
    import rv32i_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst_n_i,
    // instruction side, read implied every cycle
    input  wire logic [`XLEN-1:0] instr_mem_rdata_i,
    output logic      [`XLEN-1:0] instr_mem_address_o,
    // data side, word access only
    input  wire logic [`XLEN-1:0] data_mem_rdata_i,
    output logic      [`XLEN-1:0] data_mem_address_o,
    output logic      [`XLEN-1:0] data_mem_wdata_o,
    output logic                  data_read_o,
    output logic                  data_write_o
);

    logic [`XLEN-1:0]       if_id_instr;
    id_ex_t                 id_ex;
    fwd_sel_e               fwd_a;
    fwd_sel_e               fwd_b;
    // writeback bus, back into decode and execute
    logic                   wb_we;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;

    ex_mem_if ex_mem_bus ();

    fetch_unit u_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_rdata_i (instr_mem_rdata_i),
        .pc_o          (instr_mem_address_o),
        .instr_o       (if_id_instr)
    );

    decode_unit u_decode (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .instr_i   (if_id_instr),
        .wb_we_i   (wb_we),
        .wb_rd_i   (wb_rd),
        .wb_data_i (wb_data),
        .id_ex_o   (id_ex)
    );

    forwarder u_forwarder (
        .id_ex_rs1_i (id_ex.rs1),
        .id_ex_rs2_i (id_ex.rs2),
        .mem_bus     (ex_mem_bus.fwd),
        .wb_we_i     (wb_we),
        .wb_rd_i     (wb_rd),
        .fwd_a_o     (fwd_a),
        .fwd_b_o     (fwd_b)
    );

    execute_unit u_execute (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .id_ex_i   (id_ex),
        .fwd_a_i   (fwd_a),
        .fwd_b_i   (fwd_b),
        .wb_data_i (wb_data),
        .mem_bus   (ex_mem_bus.ex)
    );

    mem_wb_unit u_mem_wb (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .mem_bus        (ex_mem_bus.mem),
        .data_rdata_i   (data_mem_rdata_i),
        .data_address_o (data_mem_address_o),
        .data_wdata_o   (data_mem_wdata_o),
        .data_read_o    (data_read_o),
        .data_write_o   (data_write_o),
        .wb_we_o        (wb_we),
        .wb_rd_o        (wb_rd),
        .wb_data_o      (wb_data)
    );

endmodule

`default_nettype wire

// ==== verif/datapath_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath_tb;

    localparam int          NUM_BLOCKS = 36;
    localparam logic [6:0]  OPC_IMM    = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
    localparam logic [31:0] NOP        = 32'h0000_0013;

    logic        clk;
    logic        rst_n_i;
    logic [31:0] instr_mem_rdata_i;
    logic [31:0] instr_mem_address_o;
    logic [31:0] data_mem_rdata_i;
    logic [31:0] data_mem_address_o;
    logic [31:0] data_mem_wdata_o;
    logic        data_read_o;
    logic        data_write_o;

    // program, data memory model and the reference machine state
    logic [31:0] prog [256];
    logic [31:0] dmem [64];
    logic [31:0] shadow_mem [64];
    logic [31:0] xreg [32];
    logic [31:0] store_addr_q [$];
    logic [31:0] store_data_q [$];
    logic [31:0] load_q [$];
    logic [31:0] lfsr_q;
    int          prog_len;

    datapath dut_i (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .instr_mem_rdata_i   (instr_mem_rdata_i),
        .instr_mem_address_o (instr_mem_address_o),
        .data_mem_rdata_i    (data_mem_rdata_i),
        .data_mem_address_o  (data_mem_address_o),
        .data_mem_wdata_o    (data_mem_wdata_o),
        .data_read_o         (data_read_o),
        .data_write_o        (data_write_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // both memories answer in the same cycle
    // fetch past the program end sees no-ops
    assign instr_mem_rdata_i = (instr_mem_address_o < 32'd1024) ?
                               prog[instr_mem_address_o[9:2]] : NOP;
    assign data_mem_rdata_i  = dmem[data_mem_address_o[7:2]];

    // fibonacci lfsr with taps at 32 22 2 1
    // one step per output bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    // unwritten words differ at every address
    function automatic logic [31:0] word_fill(input logic [31:0] addr);
        return (addr ^ 32'h6b1d_e5a3) + {addr[15:0], addr[31:16]};
    endfunction

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // stores are always word wide
    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] bits;
        bits = rand_bits(5);
        return (bits[4:0] == 5'd0) ? 5'd1 : bits[4:0];
    endfunction

    function automatic logic [11:0] word_offset();
        logic [31:0] bits;
        bits = rand_bits(6);
        return {4'b0, bits[5:0], 2'b00};
    endfunction

    // random OP-IMM where shifts keep a legal funct7
    function automatic logic [31:0] imm_op(input logic [4:0] rd, input logic [4:0] rs1);
        logic [31:0] bits;
        logic [2:0]  f3;
        logic [11:0] imm;
        bits = rand_bits(3);
        f3   = bits[2:0];
        bits = rand_bits(12);
        imm  = bits[11:0];
        if (f3 == 3'b001) begin
            imm = {7'b0, bits[4:0]};
        end else if (f3 == 3'b101) begin
            // bit 10 picks SRAI
            imm = {1'b0, bits[10], 5'b0, bits[4:0]};
        end
        return i_type(imm, rs1, f3, rd, OPC_IMM);
    endfunction

    // random OP with the alternate funct7 only on SUB and SRA
    function automatic logic [31:0] reg_op(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        logic [31:0] bits;
        logic [2:0]  f3;
        logic        alt;
        bits = rand_bits(3);
        f3   = bits[2:0];
        alt  = 1'b0;
        if (f3 == 3'b000 || f3 == 3'b101) begin
            bits = rand_bits(1);
            alt  = bits[0];
        end
        return r_type({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
    endfunction

    task automatic emit(input logic [31:0] ins);
        prog[prog_len] = ins;
        prog_len++;
    endtask

    task automatic build_program();
        int          kind;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rc;
        logic [11:0] off;
        logic [11:0] off2;
        logic [31:0] bits;
        for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
            // every block kind once before the random picks
            kind = (blk < 6) ? blk : int'(rand_bits(3) % 32'd6);
            ra   = pick_reg();
            rb   = pick_reg();
            rc   = pick_reg();
            off  = word_offset();
            off2 = word_offset();
            case (kind)
                // store takes the result from the memory stage
                0: begin
                    emit(imm_op(rc, ra));
                    emit(s_type(off, rc, 5'd0));
                end
                // rs1 from writeback and rs2 from memory
                1: begin
                    emit(imm_op(ra, rc));
                    emit(imm_op(rb, rc));
                    emit(reg_op(rc, ra, rb));
                    emit(s_type(off, rc, 5'd0));
                end
                // ra written one and two back so the newer one must win
                2: begin
                    emit(imm_op(ra, rb));
                    emit(imm_op(ra, ra));
                    emit(reg_op(rc, ra, rb));
                    emit(s_type(off, rc, 5'd0));
                end
                // store three slots after LUI reads through the regfile
                3: begin
                    bits = rand_bits(20);
                    emit(u_type(bits[19:0], ra));
                    emit(NOP);
                    emit(NOP);
                    emit(s_type(off, ra, 5'd0));
                end
                // store, load back, then store the loaded value
                4: begin
                    emit(s_type(off, rc, 5'd0));
                    emit(NOP);
                    emit(NOP);
                    emit(i_type(off, 5'd0, 3'b010, rb, OPC_LOAD));
                    // slot after a load never reads its rd
                    emit(NOP);
                    emit(s_type(off2, rb, 5'd0));
                end
                // writes to x0 are dropped
                5: begin
                    emit(imm_op(5'd0, ra));
                    emit(reg_op(5'd0, ra, rb));
                    emit(s_type(off, 5'd0, 5'd0));
                end
                default: emit(NOP);
            endcase
        end
        // drain the pipe
        repeat (4) emit(NOP);
    endtask

    // ISA result for OP and OP-IMM by funct3
    function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // one instruction of the in-order reference machine
    task automatic isa_step(input logic [31:0] ins);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] i_imm;
        logic [31:0] s_imm;
        logic [31:0] addr;
        logic [31:0] res;
        logic        wr;
        rd    = ins[11:7];
        f3    = ins[14:12];
        a     = xreg[ins[19:15]];
        b     = xreg[ins[24:20]];
        i_imm = {{20{ins[31]}}, ins[31:20]};
        s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        wr    = 1'b1;
        res   = '0;
        case (ins[6:0])
            7'b0110111: res = {ins[31:12], 12'b0};
            7'b0010011: res = isa_alu(f3, ins[30] && (f3 == 3'b101), a, i_imm);
            7'b0110011: res = isa_alu(f3, ins[30], a, b);
            7'b0000011: begin
                addr = a + i_imm;
                load_q.push_back(addr);
                res = shadow_mem[addr[7:2]];
            end
            7'b0100011: begin
                addr = a + s_imm;
                store_addr_q.push_back(addr);
                store_data_q.push_back(b);
                shadow_mem[addr[7:2]] = b;
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) begin
            xreg[rd] = res;
        end
    endtask

    task automatic fail_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        fail_run();
    endtask

    task automatic unexpected_strobe(input string msg);
        $display("error at t=%0t: %s", $time, msg);
        fail_run();
    endtask

    task automatic quiet_strobes();
        assert (!data_read_o) else value_mismatch("data_read_o", {31'b0, data_read_o}, 32'd0);
        assert (!data_write_o) else value_mismatch("data_write_o", {31'b0, data_write_o}, 32'd0);
    endtask

    // store strobe against the next reference store before the memory update
    task automatic check_store();
        logic [31:0] exp_a;
        logic [31:0] exp_d;
        if (data_write_o) begin
            assert (store_addr_q.size() != 0)
            else unexpected_strobe("store strobe after the last expected store");
            exp_a = store_addr_q.pop_front();
            exp_d = store_data_q.pop_front();
            assert (data_mem_address_o == exp_a)
            else value_mismatch("data_mem_address_o", data_mem_address_o, exp_a);
            assert (data_mem_wdata_o == exp_d)
            else value_mismatch("data_mem_wdata_o", data_mem_wdata_o, exp_d);
            dmem[data_mem_address_o[7:2]] = data_mem_wdata_o;
        end
    endtask

    task automatic check_load();
        logic [31:0] exp_a;
        if (data_read_o) begin
            assert (load_q.size() != 0)
            else unexpected_strobe("load strobe after the last expected load");
            exp_a = load_q.pop_front();
            assert (data_mem_address_o == exp_a)
            else value_mismatch("data_mem_address_o", data_mem_address_o, exp_a);
        end
    endtask

    initial begin
        int          cyc;
        int          limit;
        logic [31:0] exp_pc;
        logic        finished;
        rst_n_i  = 1'b0;
        lfsr_q   = 32'he711;
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            prog[i] = NOP;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]       = word_fill(32'(i * 4));
            shadow_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            xreg[i] = '0;
        end
        build_program();
        for (int i = 0; i < prog_len; i++) begin
            isa_step(prog[i]);
        end

        // two rising edges in reset
        repeat (2) begin
            @(negedge clk);
            quiet_strobes();
        end
        rst_n_i = 1'b1;

        cyc      = 0;
        exp_pc   = 32'h0;
        limit    = prog_len + 20;
        finished = 1'b0;
        while (!finished && cyc < limit) begin
            assert (instr_mem_address_o == exp_pc)
            else value_mismatch("instr_mem_address_o", instr_mem_address_o, exp_pc);
            // first instruction reaches memory in cycle 3
            if (cyc < 3) begin
                quiet_strobes();
            end
            check_store();
            check_load();
            exp_pc = exp_pc + 32'd4;
            @(negedge clk);
            cyc++;
            finished = (store_addr_q.size() == 0) && (load_q.size() == 0) &&
                       (cyc > prog_len + 4);
        end

        if (finished) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("timeout after %0d cycles, %0d stores and %0d loads never seen",
                     cyc, store_addr_q.size(), load_q.size());
            fail_run();
        end
    end

endmodule

`default_nettype wire

// ==== rv32i_pipe.f ====
+incdir+src
src/rv32i_pkg.sv
src/ex_mem_if.sv
src/fetch_unit.sv
src/regfile.sv
src/decode_unit.sv
src/forwarder.sv
src/execute_unit.sv
src/mem_wb_unit.sv
src/datapath.sv
verif/datapath_tb.sv

// ==== Makefile ====
TOP := datapath_tb
OBJ := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f rv32i_pipe.f --top-module datapath

# pass only if the pass line shows up in the simulation output
sim:
	verilator --binary --timing --assert -f rv32i_pipe.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ)
